// ==== acq_pkg.sv ====
`default_nettype none

package acq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // raw converter word, top 14 bits carry the sample
  localparam int unsigned ADC_RAW_W  = 16;
  localparam int unsigned SMP_W      = 14;
  // calibration gain, 16384 is unity
  localparam int unsigned GAIN_W     = 16;
  localparam int unsigned GAIN_SHIFT = 14;
  // free running time stamp
  localparam int unsigned TS_W       = 64;
  // debounce length in adc_clk cycles
  localparam int unsigned DEB_W      = 20;
  // number of samples marked after the trigger
  localparam int unsigned POST_W     = 16;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;
  typedef logic signed [SMP_W-1:0]     smp_t;
  typedef logic signed [GAIN_W-1:0]    gain_t;
  typedef logic signed [SMP_W-1:0]     offset_t;
  typedef logic        [TS_W-1:0]      ts_t;
  typedef logic        [DEB_W-1:0]     deb_len_t;
  typedef logic        [POST_W-1:0]    post_len_t;

  // saturation limits of a sample
  localparam smp_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};
  localparam smp_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};

  // acquisition controller states
  typedef enum logic [1:0] {
    ACQ_IDLE  = 2'd0,
    ACQ_ARMED = 2'd1,
    ACQ_POST  = 2'd2,
    ACQ_DONE  = 2'd3
  } acq_state_t;

endpackage : acq_pkg

`default_nettype wire

// ==== adc_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_frontend import acq_pkg::*; (
  // clock and reset
  input  logic     adc_clk,
  input  logic     top_rst,
  // raw converter word
  input  adc_raw_t adc_dat_i,
  // signed sample, one cycle later
  output smp_t     smp_o
);

  ////////////////////////////////////////////////////////////////////////////
  // offset binary to two's complement
  ////////////////////////////////////////////////////////////////////////////

  // converted word before the register
  smp_t smp_cnv;

  // sign bit passes as is
  // remaining bits are inverted, which also flips the slope
  // two lowest bits of the 16 bit word are reserved
  assign smp_cnv = {adc_dat_i[ADC_RAW_W-1],
                    ~adc_dat_i[ADC_RAW_W-2:ADC_RAW_W-SMP_W]};

  ////////////////////////////////////////////////////////////////////////////
  // input register
  ////////////////////////////////////////////////////////////////////////////

  // meant to land in the IO block registers
  smp_t smp_q;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_q <= '0;
    end else begin
      smp_q <= smp_cnv;
    end
  end

  // straight out of the register
  assign smp_o = smp_q;

endmodule : adc_frontend

`default_nettype wire

// ==== calib_linear.sv ====
`timescale 1ns/1ns
`default_nettype none

module calib_linear import acq_pkg::*; (
  // clock and reset
  input  logic    adc_clk,
  input  logic    top_rst,
  // converted sample
  input  smp_t    smp_i,
  // calibration settings
  input  gain_t   gain_i,
  input  offset_t offset_i,
  // calibrated sample, two cycles later
  output smp_t    smp_o
);

  ////////////////////////////////////////////////////////////////////////////
  // stage one, gain
  ////////////////////////////////////////////////////////////////////////////

  // full width product, no rounding yet
  logic signed [SMP_W+GAIN_W-1:0] prod_q;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= smp_i * gain_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage two, offset and saturation
  ////////////////////////////////////////////////////////////////////////////

  // product scaled back, unity gain leaves the sample unchanged
  logic signed [SMP_W+GAIN_W-1:0] prod_sh;
  // one extra bit so the sum never wraps
  logic signed [SMP_W+GAIN_W:0]   sum;
  // clamp flags
  logic                           pos_ovf;
  logic                           neg_ovf;
  smp_t                           smp_q;

  assign prod_sh = prod_q >>> GAIN_SHIFT;
  // offset is sign extended by the signed add
  assign sum     = prod_sh + offset_i;

  assign pos_ovf = (sum > SMP_MAX);
  assign neg_ovf = (sum < SMP_MIN);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_q <= '0;
    end else if (pos_ovf) begin
      smp_q <= SMP_MAX;
    end else if (neg_ovf) begin
      smp_q <= SMP_MIN;
    end else begin
      smp_q <= sum[SMP_W-1:0];
    end
  end

  assign smp_o = smp_q;

  // the two clamps exclude each other for any gain and offset
  a_clamp_excl : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !(pos_ovf && neg_ovf)
  );

endmodule : calib_linear

`default_nettype wire

// ==== trigger_debounce.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_debounce import acq_pkg::*; (
  // clock and reset
  input  logic     adc_clk,
  input  logic     top_rst,
  // asynchronous connector pin
  input  logic     pin_i,
  // cycles a change must hold
  input  deb_len_t deb_len_i,
  // debounced level and its edges
  output logic     lvl_o,
  output logic     rise_o,
  output logic     fall_o
);

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // two flops, the pin has no relation to adc_clk
  logic [1:0] sync_q;
  logic       din;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], pin_i};
    end
  end

  assign din = sync_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // debounce timer
  ////////////////////////////////////////////////////////////////////////////

  deb_len_t cnt_q;
  deb_len_t cnt_nxt;
  logic     lvl_q;
  logic     flip;
  logic     rise_q;
  logic     fall_q;

  // cycles the input has differed so far, this one included
  assign cnt_nxt = cnt_q + 1'b1;
  // input differs and has held long enough
  assign flip    = (din != lvl_q) && (cnt_nxt >= deb_len_i);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cnt_q  <= '0;
      lvl_q  <= 1'b0;
      rise_q <= 1'b0;
      fall_q <= 1'b0;
    end else begin
      // a glitch back to the stable level restarts the timer
      if ((din == lvl_q) || flip) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_nxt;
      end
      if (flip) begin
        lvl_q <= din;
      end
      // edge pulses registered with the level itself
      rise_q <= flip &  din;
      fall_q <= flip & ~din;
    end
  end

  assign lvl_o  = lvl_q;
  assign rise_o = rise_q;
  assign fall_o = fall_q;

  // a single flip never produces both edges
  a_edge_excl : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !(rise_o && fall_o)
  );

endmodule : trigger_debounce

`default_nettype wire

// ==== acq_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module acq_ctrl import acq_pkg::*; (
  // clock and reset
  input  logic      adc_clk,
  input  logic      top_rst,
  // software control
  input  logic      arm_i,
  input  logic      sw_trg_i,
  // external trigger enable and edge select, high selects falling
  input  logic      ext_en_i,
  input  logic      ext_edge_i,
  // debounced edges
  input  logic      rise_i,
  input  logic      fall_i,
  // post trigger sample count
  input  post_len_t post_len_i,
  // status and sample marking
  output logic      armed_o,
  output logic      trg_o,
  output ts_t       trg_ts_o,
  output logic      smp_vld_o,
  output logic      done_o
);

  ////////////////////////////////////////////////////////////////////////////
  // time stamp
  ////////////////////////////////////////////////////////////////////////////

  // zero in the first cycle out of reset
  ts_t cts_q;
  ts_t cts_nxt;

  assign cts_nxt = cts_q + 1'b1;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cts_q <= '0;
    end else begin
      cts_q <= cts_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // trigger source
  ////////////////////////////////////////////////////////////////////////////

  logic ext_trg;
  logic trg_in;

  assign ext_trg = ext_en_i & (ext_edge_i ? fall_i : rise_i);
  assign trg_in  = sw_trg_i | ext_trg;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  acq_state_t state_q;
  // samples still to mark
  post_len_t  cnt_q;
  logic       trg_q;
  ts_t        trg_ts_q;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q  <= ACQ_IDLE;
      cnt_q    <= '0;
      trg_q    <= 1'b0;
      trg_ts_q <= '0;
    end else begin
      // trigger pulse lasts one cycle
      trg_q <= 1'b0;
      case (state_q)
        ACQ_IDLE, ACQ_DONE: begin
          if (arm_i) begin
            state_q <= ACQ_ARMED;
          end
        end
        ACQ_ARMED: begin
          if (trg_in) begin
            state_q  <= ACQ_POST;
            trg_q    <= 1'b1;
            // stamp matches cts in the cycle trg_o is high
            trg_ts_q <= cts_nxt;
            cnt_q    <= post_len_i;
          end
        end
        ACQ_POST: begin
          if (trg_q) begin
            // zero length goes straight to done
            if (cnt_q == '0) begin
              state_q <= ACQ_DONE;
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
            // last marked sample
            if (cnt_q == post_len_t'(1)) begin
              state_q <= ACQ_DONE;
            end
          end
        end
        default: begin
          state_q <= ACQ_IDLE;
        end
      endcase
    end
  end

  // status from the state
  assign armed_o   = (state_q == ACQ_ARMED);
  assign done_o    = (state_q == ACQ_DONE);
  // trigger cycle itself carries no valid sample
  assign smp_vld_o = (state_q == ACQ_POST) && !trg_q;
  assign trg_o     = trg_q;
  assign trg_ts_o  = trg_ts_q;

  // valid only inside POST, and never in the cycle POST is entered
  a_vld_in_post : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    smp_vld_o |-> (state_q == ACQ_POST) && $past(state_q == ACQ_POST)
  );

  // one trigger per arm
  a_trg_pulse : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    trg_o |=> !trg_o
  );

endmodule : acq_ctrl

`default_nettype wire

// ==== acq_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module acq_top import acq_pkg::*; (
  // clock and reset
  input  logic      adc_clk,
  input  logic      top_rst,
  // ADC
  input  adc_raw_t  adc_dat_i,
  // calibration
  input  gain_t     gain_i,
  input  offset_t   offset_i,
  // expansion connector trigger pin
  input  logic      exp_pin_i,
  input  deb_len_t  deb_len_i,
  // acquisition control
  input  logic      arm_i,
  input  logic      sw_trg_i,
  input  logic      ext_en_i,
  input  logic      ext_edge_i,
  input  post_len_t post_len_i,
  // sample stream
  output smp_t      smp_dat_o,
  output logic      smp_vld_o,
  // trigger and status
  output logic      trg_o,
  output ts_t       trg_ts_o,
  output logic      armed_o,
  output logic      done_o,
  output logic      ext_lvl_o
);

  ////////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////////

  // converted, not yet calibrated
  smp_t adc_smp;

  adc_frontend adc_frontend_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .smp_o     (adc_smp)
  );

  calib_linear calib_linear_i (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .smp_i    (adc_smp),
    .gain_i   (gain_i),
    .offset_i (offset_i),
    .smp_o    (smp_dat_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // trigger and control
  ////////////////////////////////////////////////////////////////////////////

  // debounced pin edges
  logic ext_rise;
  logic ext_fall;

  trigger_debounce trigger_debounce_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pin_i     (exp_pin_i),
    .deb_len_i (deb_len_i),
    .lvl_o     (ext_lvl_o),
    .rise_o    (ext_rise),
    .fall_o    (ext_fall)
  );

  acq_ctrl acq_ctrl_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .arm_i      (arm_i),
    .sw_trg_i   (sw_trg_i),
    .ext_en_i   (ext_en_i),
    .ext_edge_i (ext_edge_i),
    .rise_i     (ext_rise),
    .fall_i     (ext_fall),
    .post_len_i (post_len_i),
    .armed_o    (armed_o),
    .trg_o      (trg_o),
    .trg_ts_o   (trg_ts_o),
    .smp_vld_o  (smp_vld_o),
    .done_o     (done_o)
  );

endmodule : acq_top

`default_nettype wire

// ==== tb_acq_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_acq_top import acq_pkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // run lengths
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_HALF   = 20;
  localparam int RST_CYCLES = 16;
  localparam int DRV_DLY    = 2;
  // each word held 4 cycles and read 3 cycles after it is applied
  localparam int HOLD       = 4;
  localparam int LAT        = 3;
  localparam int N_CONV     = 16;
  localparam int N_CAL      = 24;
  localparam int N_SAT      = 5;
  localparam int POST_LEN   = 5;
  localparam int DEB_LEN    = 8;
  // bound of one wait covers debounce latency and the post-trigger run
  localparam int WAIT_LIM   = 4 * DEB_LEN + 32;
  localparam int DATA_CYC   = (N_CONV + N_CAL + N_SAT) * HOLD;
  // 12 bounded waits plus the short-pulse window and a few single steps
  localparam int CTRL_CYC   = 12 * WAIT_LIM + 3 * DEB_LEN + 40;
  localparam int MAX_CYCLES = RST_CYCLES + DATA_CYC + CTRL_CYC + 100;
  localparam longint LIM_HI = 2**(SMP_W-1) - 1;
  localparam longint LIM_LO = -(2**(SMP_W-1));

  logic      adc_clk;
  logic      top_rst;
  adc_raw_t  adc_dat_i;
  gain_t     gain_i;
  offset_t   offset_i;
  logic      exp_pin_i;
  deb_len_t  deb_len_i;
  logic      arm_i;
  logic      sw_trg_i;
  logic      ext_en_i;
  logic      ext_edge_i;
  post_len_t post_len_i;
  smp_t      smp_dat_o;
  logic      smp_vld_o;
  logic      trg_o;
  ts_t       trg_ts_o;
  logic      armed_o;
  logic      done_o;
  logic      ext_lvl_o;

  integer seed;
  int     err_cnt;
  int     chk_cnt;
  int     test_cnt;
  int     test_err;
  int     trg_cnt;
  int     wd_cnt;
  string  cur_test;
  // model of the DUT time stamp
  ts_t    cyc;
  // output expected while the next word is still in the pipeline
  longint prev_exp;

  acq_top dut0 (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .gain_i     (gain_i),
    .offset_i   (offset_i),
    .exp_pin_i  (exp_pin_i),
    .deb_len_i  (deb_len_i),
    .arm_i      (arm_i),
    .sw_trg_i   (sw_trg_i),
    .ext_en_i   (ext_en_i),
    .ext_edge_i (ext_edge_i),
    .post_len_i (post_len_i),
    .smp_dat_o  (smp_dat_o),
    .smp_vld_o  (smp_vld_o),
    .trg_o      (trg_o),
    .trg_ts_o   (trg_ts_o),
    .armed_o    (armed_o),
    .done_o     (done_o),
    .ext_lvl_o  (ext_lvl_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #CLK_HALF adc_clk = ~adc_clk;
  end

  // zero in the first cycle out of reset
  always @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

  // trigger pulses counted mid-cycle
  always @(negedge adc_clk) begin
    if (top_rst) begin
      trg_cnt <= 0;
    end else if (trg_o) begin
      trg_cnt <= trg_cnt + 1;
    end
  end

  initial begin
    wd_cnt = 0;
    while (wd_cnt < MAX_CYCLES) begin
      @(posedge adc_clk);
      wd_cnt++;
    end
    $display("timeout in test %s after %0d cycles", cur_test, MAX_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // drive and sample point just after the edge
  task automatic tick();
    @(posedge adc_clk);
    #DRV_DLY;
  endtask

  task automatic check_val(input string what, input longint exp_v, input longint act_v);
    chk_cnt++;
    assert (exp_v == act_v) else begin
      $display("mismatch %s %s expected %0d actual %0d", cur_test, what, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    chk_cnt++;
    assert (cond) else begin
      $display("error in %s: %s", cur_test, what);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = err_cnt;
  endtask

  task automatic finish_test();
    test_cnt++;
    $display("test %s finished with %0d errors", cur_test, err_cnt - test_err);
  endtask

  // offset binary word to signed sample
  task automatic convert_word(input adc_raw_t raw, output longint smp_v);
    logic [SMP_W-1:0] cnv;
    cnv   = {raw[15], ~raw[14:2]};
    smp_v = longint'($signed(cnv));
  endtask

  // scaled product plus offset clamped to the sample range
  task automatic calibrate(input longint smp_v, input gain_t g, input offset_t off,
                           output longint exp_v);
    longint sum;
    sum = ((smp_v * longint'(g)) >>> GAIN_SHIFT) + longint'(off);
    if (sum > LIM_HI) begin
      exp_v = LIM_HI;
    end else if (sum < LIM_LO) begin
      exp_v = LIM_LO;
    end else begin
      exp_v = sum;
    end
  endtask

  task automatic apply_and_check(input adc_raw_t raw, input gain_t g, input offset_t off,
                                 input bit early_chk);
    longint smp_v;
    longint exp_v;
    convert_word(raw, smp_v);
    calibrate(smp_v, g, off, exp_v);
    adc_dat_i = raw;
    gain_i    = g;
    offset_i  = off;
    repeat (LAT - 1) tick();
    // one cycle early the pipeline still carries the previous word
    if (early_chk) begin
      check_val("smp_dat_o before latency", prev_exp, smp_dat_o);
    end
    tick();
    check_val("smp_dat_o", exp_v, smp_dat_o);
    prev_exp = exp_v;
    repeat (HOLD - LAT) tick();
  endtask

  task automatic pulse_arm();
    arm_i = 1'b1;
    tick();
    arm_i = 1'b0;
  endtask

  task automatic wait_level(input logic lvl);
    int n;
    n = 0;
    while (ext_lvl_o !== lvl && n < WAIT_LIM) begin
      tick();
      n++;
    end
    check_true(ext_lvl_o === lvl, "ext_lvl_o did not follow a long pin change");
  endtask

  // stamp must equal the modeled counter in the trg_o cycle
  task automatic wait_trigger(output ts_t ts_v);
    int n;
    n    = 0;
    ts_v = '0;
    while (!trg_o && n < WAIT_LIM) begin
      tick();
      n++;
    end
    check_true(trg_o, "trg_o did not pulse while armed");
    if (trg_o) begin
      check_val("trg_ts_o", longint'(cyc), longint'(trg_ts_o));
      check_true(!smp_vld_o, "smp_vld_o high in the trigger cycle");
      ts_v = trg_ts_o;
    end
  endtask

  task automatic count_valid(input int exp_len);
    int n;
    int vld_n;
    bit prev_vld;
    bit prev_trg;
    bit seen_done;
    bit bad_seq;
    n         = 0;
    vld_n     = 0;
    prev_vld  = 1'b0;
    prev_trg  = 1'b0;
    seen_done = 1'b0;
    bad_seq   = 1'b0;
    while (!seen_done && n < WAIT_LIM) begin
      prev_vld = smp_vld_o;
      prev_trg = trg_o;
      tick();
      n++;
      if (done_o) begin
        seen_done = 1'b1;
      end else if (smp_vld_o) begin
        // first sample right after trg_o and the rest back to back
        if (vld_n == 0 ? !prev_trg : !prev_vld) begin
          bad_seq = 1'b1;
        end
        vld_n++;
      end
    end
    check_true(seen_done, "done_o did not rise after the trigger");
    check_val("smp_vld_o cycles", exp_len, vld_n);
    check_true(!bad_seq, "smp_vld_o cycles were not contiguous after trg_o");
    check_true(exp_len == 0 ? prev_trg : prev_vld,
               "done_o did not rise right after the last sample");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ts_t ts_a;
    ts_t ts_b;
    int  base;
    bit  moved;
    seed       = 32'hdc28;
    err_cnt    = 0;
    chk_cnt    = 0;
    test_cnt   = 0;
    prev_exp   = 0;
    cur_test   = "reset";
    top_rst    = 1'b1;
    adc_dat_i  = '0;
    gain_i     = gain_t'(16384);
    offset_i   = '0;
    exp_pin_i  = 1'b0;
    deb_len_i  = deb_len_t'(DEB_LEN);
    arm_i      = 1'b0;
    sw_trg_i   = 1'b0;
    ext_en_i   = 1'b0;
    ext_edge_i = 1'b0;
    post_len_i = post_len_t'(POST_LEN);
    repeat (RST_CYCLES) @(posedge adc_clk);
    #DRV_DLY;
    top_rst = 1'b0;
    check_true(!smp_vld_o && !trg_o && !done_o && !armed_o,
               "status outputs not low after reset");
    check_val("trg_ts_o after reset", 0, longint'(trg_ts_o));

    start_test("conversion");
    for (int i = 0; i < N_CONV; i++) begin
      apply_and_check(adc_raw_t'($random(seed)), gain_t'(16384), '0, 1'b1);
    end
    finish_test();

    start_test("calibration");
    for (int i = 0; i < N_CAL; i++) begin
      apply_and_check(adc_raw_t'($random(seed)), gain_t'($random(seed)),
                      offset_t'($random(seed)), 1'b0);
    end
    // full scale words against large gains and offsets hit both clamps
    apply_and_check(16'h0000, gain_t'(32767), '0, 1'b0);
    apply_and_check(16'hfffc, gain_t'(32767), '0, 1'b0);
    apply_and_check(16'h0000, gain_t'(16384), offset_t'(8191), 1'b0);
    apply_and_check(16'hfffc, gain_t'(16384), offset_t'(-8192), 1'b0);
    apply_and_check(16'hfffc, gain_t'(-32768), '0, 1'b0);
    finish_test();

    start_test("sw_trigger");
    base     = trg_cnt;
    sw_trg_i = 1'b1;
    repeat (2) tick();
    sw_trg_i = 1'b0;
    repeat (2) tick();
    check_val("trg_o pulses before arm", base, trg_cnt);
    pulse_arm();
    check_val("armed_o", 1, armed_o);
    // held high through POST without a retrigger
    sw_trg_i = 1'b1;
    wait_trigger(ts_a);
    check_val("armed_o after trigger", 0, armed_o);
    count_valid(POST_LEN);
    sw_trg_i = 1'b0;
    tick();
    check_val("trg_o pulses per arm", base + 1, trg_cnt);
    check_val("done_o held", 1, done_o);
    finish_test();

    start_test("ext_trigger");
    ext_en_i = 1'b1;
    pulse_arm();
    base  = trg_cnt;
    moved = 1'b0;
    // glitch of half the debounce length
    for (int i = 0; i < 3 * DEB_LEN; i++) begin
      exp_pin_i = (i < DEB_LEN / 2);
      tick();
      if (ext_lvl_o) begin
        moved = 1'b1;
      end
    end
    check_true(!moved, "ext_lvl_o changed on a pulse shorter than deb_len_i");
    check_val("trg_o pulses on short pulse", base, trg_cnt);
    check_val("armed_o after short pulse", 1, armed_o);
    exp_pin_i = 1'b1;
    wait_trigger(ts_a);
    check_val("ext_lvl_o at rising trigger", 1, ext_lvl_o);
    count_valid(POST_LEN);
    exp_pin_i = 1'b0;
    wait_level(1'b0);
    // falling edge selected so the rise is ignored
    ext_edge_i = 1'b1;
    pulse_arm();
    base      = trg_cnt;
    exp_pin_i = 1'b1;
    wait_level(1'b1);
    repeat (2) tick();
    check_val("trg_o pulses on rise with falling select", base, trg_cnt);
    check_val("armed_o after rise", 1, armed_o);
    exp_pin_i = 1'b0;
    wait_trigger(ts_a);
    check_val("ext_lvl_o at falling trigger", 0, ext_lvl_o);
    count_valid(POST_LEN);
    finish_test();

    start_test("rearm_zero_len");
    ext_en_i   = 1'b0;
    ext_edge_i = 1'b0;
    post_len_i = '0;
    check_val("done_o before re-arm", 1, done_o);
    pulse_arm();
    check_val("done_o after re-arm", 0, done_o);
    check_val("armed_o after re-arm", 1, armed_o);
    sw_trg_i = 1'b1;
    wait_trigger(ts_a);
    sw_trg_i = 1'b0;
    count_valid(0);
    pulse_arm();
    sw_trg_i = 1'b1;
    wait_trigger(ts_b);
    sw_trg_i = 1'b0;
    count_valid(0);
    check_true(ts_b > ts_a, "trg_ts_o of the second run is not larger than the first");
    finish_test();

    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_acq_top

`default_nettype wire

// ==== acq.f ====
acq_pkg.sv
adc_frontend.sv
calib_linear.sv
trigger_debounce.sv
acq_ctrl.sv
acq_top.sv
tb_acq_top.sv

// ==== Makefile ====
# Verilator flow for the acq project

VERILATOR  ?= verilator
TOP        := tb_acq_top
FLIST      := acq.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
LINT_FLAGS := --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# a crash without a summary line also counts as a failure
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
